/* pmu_params.svh */
// PMU sizes, field widths and register address map
`ifndef PMU_PARAMS_SVH
`define PMU_PARAMS_SVH

// Datapath sizes
`define PMU_REG_WIDTH      32
`define PMU_N_COUNTERS     4
`define PMU_N_SOC_EV       16
`define PMU_SEL_BITS       4
`define PMU_CNT_IDX_BITS   2
`define PMU_XBAR_WIDTH     (`PMU_N_COUNTERS * `PMU_SEL_BITS)

// --------------------------------------------------
// Register map
// --------------------------------------------------
`define PMU_ADDR_WIDTH       4
`define PMU_ADDR_CFG         4'd0
// Counters sit at 1..4
`define PMU_ADDR_CNT_BASE    4'd1
`define PMU_ADDR_CNT_LAST    4'd4
`define PMU_ADDR_OVF_MASK    4'd5
// Read only
`define PMU_ADDR_OVF_VECT    4'd6
`define PMU_ADDR_QUOTA_MASK  4'd7
`define PMU_ADDR_QUOTA_LIMIT 4'd8
`define PMU_ADDR_XBAR        4'd9

`endif

/* pmu_pkg.sv */
// PMU shared types: register requests, decoded configuration, counter buses
`include "pmu_params.svh"

package pmu_pkg;

    // Event source override, bits 31:30 of the configuration register
    typedef enum logic [1:0] {
        SELFTEST_OFF     = 2'd0,
        SELFTEST_ALL_ON  = 2'd1,
        SELFTEST_ALL_OFF = 2'd2,
        SELFTEST_ONE_ON  = 2'd3
    } selftest_e;

    // Register access opcode
    typedef enum logic [1:0] {
        REG_IDLE  = 2'd0,
        REG_READ  = 2'd1,
        REG_WRITE = 2'd2
    } reg_op_e;

    // Single-port register request from the host
    typedef struct packed {
        reg_op_e                    op;
        logic [`PMU_ADDR_WIDTH-1:0] addr;
        logic [`PMU_REG_WIDTH-1:0]  wdata;
    } reg_req_t;

    // Fields decoded out of the configuration register
    typedef struct packed {
        selftest_e selftest;
        logic      quota_softrst;
        logic      ovf_softrst;
        logic      ovf_en;
        logic      cnt_softrst;
        logic      cnt_en;
    } pmu_cfg_t;

    // All counter values, counter 0 in the lowest word
    typedef logic [`PMU_N_COUNTERS-1:0][`PMU_REG_WIDTH-1:0] cnt_vec_t;

    // Software write into one counter
    typedef struct packed {
        logic                         valid;
        logic [`PMU_CNT_IDX_BITS-1:0] index;
        logic [`PMU_REG_WIDTH-1:0]    data;
    } cnt_wr_t;

endpackage

/* pmu_ctrl.sv */
// PMU control block: configuration registers, write decode and read data return
`include "pmu_params.svh"

module pmu_ctrl (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  pmu_pkg::reg_req_t              req_i,
    input  pmu_pkg::cnt_vec_t              cnt_i,
    input  logic [`PMU_N_COUNTERS-1:0]     ovf_vect_i,
    output pmu_pkg::pmu_cfg_t              cfg_o,
    output logic [`PMU_XBAR_WIDTH-1:0]     xbar_sel_o,
    output pmu_pkg::cnt_wr_t               cnt_wr_o,
    output logic [`PMU_N_COUNTERS-1:0]     ovf_mask_o,
    output logic [`PMU_N_COUNTERS-1:0]     quota_mask_o,
    output logic [`PMU_REG_WIDTH-1:0]      quota_limit_o,
    output logic [`PMU_REG_WIDTH-1:0]      rdata_o,
    output logic                           rvalid_o
);

    // Software visible registers
    logic [`PMU_REG_WIDTH-1:0]  cfg_q;
    logic [`PMU_N_COUNTERS-1:0] ovf_mask_q;
    logic [`PMU_N_COUNTERS-1:0] quota_mask_q;
    logic [`PMU_REG_WIDTH-1:0]  quota_limit_q;
    logic [`PMU_XBAR_WIDTH-1:0] xbar_q;

    // Request decode
    logic                       is_write;
    logic                       is_read;
    logic                       is_cnt_addr;
    logic [`PMU_ADDR_WIDTH-1:0] cnt_off;
    logic [`PMU_REG_WIDTH-1:0]  rdata_d;
    logic [`PMU_REG_WIDTH-1:0]  rdata_q;
    logic                       rvalid_q;

    assign is_write    = (req_i.op == pmu_pkg::REG_WRITE);
    assign is_read     = (req_i.op == pmu_pkg::REG_READ);
    assign is_cnt_addr = (req_i.addr >= `PMU_ADDR_CNT_BASE) &&
                         (req_i.addr <= `PMU_ADDR_CNT_LAST);
    assign cnt_off     = req_i.addr - `PMU_ADDR_CNT_BASE;

    // --------------------------------------------------
    // Register writes, applied at the sampling edge
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cfg_q         <= '0;
            ovf_mask_q    <= '0;
            quota_mask_q  <= '0;
            quota_limit_q <= '0;
            xbar_q        <= '0;
        end else if (is_write) begin
            case (req_i.addr)
                `PMU_ADDR_CFG:         cfg_q         <= req_i.wdata;
                `PMU_ADDR_OVF_MASK:    ovf_mask_q    <= req_i.wdata[`PMU_N_COUNTERS-1:0];
                `PMU_ADDR_QUOTA_MASK:  quota_mask_q  <= req_i.wdata[`PMU_N_COUNTERS-1:0];
                `PMU_ADDR_QUOTA_LIMIT: quota_limit_q <= req_i.wdata;
                `PMU_ADDR_XBAR:        xbar_q        <= req_i.wdata[`PMU_XBAR_WIDTH-1:0];
                // Counters live in the counter bank, the overflow vector is read only
                default: ;
            endcase
        end
    end

    // Counter writes go straight through so they land on the same edge
    assign cnt_wr_o.valid = is_write && is_cnt_addr;
    assign cnt_wr_o.index = cnt_off[`PMU_CNT_IDX_BITS-1:0];
    assign cnt_wr_o.data  = req_i.wdata;

    // --------------------------------------------------
    // Read data, returned one cycle after the request
    // --------------------------------------------------
    always_comb begin
        rdata_d = '0;
        if (is_cnt_addr) begin
            rdata_d = cnt_i[cnt_off[`PMU_CNT_IDX_BITS-1:0]];
        end else begin
            case (req_i.addr)
                `PMU_ADDR_CFG:         rdata_d = cfg_q;
                `PMU_ADDR_OVF_MASK:    rdata_d[`PMU_N_COUNTERS-1:0] = ovf_mask_q;
                `PMU_ADDR_OVF_VECT:    rdata_d[`PMU_N_COUNTERS-1:0] = ovf_vect_i;
                `PMU_ADDR_QUOTA_MASK:  rdata_d[`PMU_N_COUNTERS-1:0] = quota_mask_q;
                `PMU_ADDR_QUOTA_LIMIT: rdata_d = quota_limit_q;
                `PMU_ADDR_XBAR:        rdata_d[`PMU_XBAR_WIDTH-1:0] = xbar_q;
                // Unused addresses read as zero
                default:               rdata_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            rvalid_q <= is_read;
            if (is_read) begin
                rdata_q <= rdata_d;
            end
        end
    end

    assign rdata_o  = rdata_q;
    assign rvalid_o = rvalid_q;

    // Configuration field decode
    always_comb begin
        cfg_o.cnt_en        = cfg_q[0];
        cfg_o.cnt_softrst   = cfg_q[1];
        cfg_o.ovf_en        = cfg_q[2];
        cfg_o.ovf_softrst   = cfg_q[3];
        cfg_o.quota_softrst = cfg_q[4];
        cfg_o.selftest      = pmu_pkg::selftest_e'(cfg_q[31:30]);
    end

    assign xbar_sel_o    = xbar_q;
    assign ovf_mask_o    = ovf_mask_q;
    assign quota_mask_o  = quota_mask_q;
    assign quota_limit_o = quota_limit_q;

endmodule

/* pmu_event_sel.sv */
// PMU event selection: per-counter crossbar with self-test override, registered
`include "pmu_params.svh"

module pmu_event_sel (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic [`PMU_N_SOC_EV-1:0]   events_i,
    input  logic [`PMU_XBAR_WIDTH-1:0] xbar_sel_i,
    input  pmu_pkg::selftest_e         selftest_i,
    output logic [`PMU_N_COUNTERS-1:0] inc_o
);

    // Crossbar output and post-override lanes
    logic [`PMU_N_COUNTERS-1:0] xbar_ev;
    logic [`PMU_N_COUNTERS-1:0] sel_ev;
    logic [`PMU_N_COUNTERS-1:0] inc_q;

    // --------------------------------------------------
    // Crossbar
    // --------------------------------------------------
    // Each lane picks one system event, lane 0 uses the lowest selector
    always_comb begin
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            xbar_ev[i] = events_i[xbar_sel_i[i*`PMU_SEL_BITS +: `PMU_SEL_BITS]];
        end
    end

    // --------------------------------------------------
    // Self-test override
    // --------------------------------------------------
    always_comb begin
        case (selftest_i)
            pmu_pkg::SELFTEST_OFF:     sel_ev = xbar_ev;
            pmu_pkg::SELFTEST_ALL_ON:  sel_ev = '1;
            pmu_pkg::SELFTEST_ALL_OFF: sel_ev = '0;
            // Only counter 0 sees a constant event
            pmu_pkg::SELFTEST_ONE_ON:  sel_ev = {{(`PMU_N_COUNTERS-1){1'b0}}, 1'b1};
            default:                   sel_ev = '0;
        endcase
    end

    // One register stage before the counters
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            inc_q <= '0;
        end else begin
            inc_q <= sel_ev;
        end
    end

    assign inc_o = inc_q;

endmodule

/* pmu_counters.sv */
// PMU counter bank: wrapping counters with enable, soft reset and software write
`include "pmu_params.svh"

module pmu_counters (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  pmu_pkg::pmu_cfg_t          cfg_i,
    input  logic [`PMU_N_COUNTERS-1:0] inc_i,
    input  pmu_pkg::cnt_wr_t           cnt_wr_i,
    output pmu_pkg::cnt_vec_t          cnt_o,
    output logic [`PMU_N_COUNTERS-1:0] wrap_o
);

    logic [`PMU_REG_WIDTH-1:0]  cnt_q [`PMU_N_COUNTERS];
    logic [`PMU_N_COUNTERS-1:0] wr_hit;
    logic [`PMU_N_COUNTERS-1:0] do_inc;

    for (genvar i = 0; i < `PMU_N_COUNTERS; i++) begin : g_cnt
        localparam logic [`PMU_CNT_IDX_BITS-1:0] IDX = i;

        // Software write to this lane
        assign wr_hit[i] = cnt_wr_i.valid && (cnt_wr_i.index == IDX);

        // Increment only when nothing of higher priority happens
        assign do_inc[i] = cfg_i.cnt_en && inc_i[i] && !wr_hit[i] && !cfg_i.cnt_softrst;

        // Soft reset, then write, then increment
        always_ff @(posedge clk_i) begin
            if (!rstn_i) begin
                cnt_q[i] <= '0;
            end else if (cfg_i.cnt_softrst) begin
                cnt_q[i] <= '0;
            end else if (wr_hit[i]) begin
                cnt_q[i] <= cnt_wr_i.data;
            end else if (do_inc[i]) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end

        // Carry out of all ones, same cycle as the wrapping increment
        assign wrap_o[i] = do_inc[i] && (&cnt_q[i]);

        assign cnt_o[i] = cnt_q[i];
    end

endmodule

/* pmu_irq.sv */
// PMU interrupts: sticky per-counter overflow vector and masked quota check
`include "pmu_params.svh"

module pmu_irq (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  pmu_pkg::pmu_cfg_t          cfg_i,
    input  pmu_pkg::cnt_vec_t          cnt_i,
    input  logic [`PMU_N_COUNTERS-1:0] wrap_i,
    input  logic [`PMU_N_COUNTERS-1:0] ovf_mask_i,
    input  logic [`PMU_N_COUNTERS-1:0] quota_mask_i,
    input  logic [`PMU_REG_WIDTH-1:0]  quota_limit_i,
    output logic [`PMU_N_COUNTERS-1:0] ovf_vect_o,
    output logic                       intr_overflow_o,
    output logic                       intr_quota_o
);

    // Two extra bits hold the carry of four 32-bit terms
    logic [`PMU_REG_WIDTH+1:0]  quota_sum;
    logic                       quota_armed;
    logic                       quota_hit;
    logic                       quota_q;
    logic [`PMU_N_COUNTERS-1:0] ovf_vect_q;

    // --------------------------------------------------
    // Overflow
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ovf_vect_q <= '0;
        end else if (cfg_i.ovf_softrst) begin
            ovf_vect_q <= '0;
        end else if (cfg_i.ovf_en) begin
            // Sticky until soft reset
            ovf_vect_q <= ovf_vect_q | wrap_i;
        end
    end

    assign ovf_vect_o      = ovf_vect_q;
    assign intr_overflow_o = |(ovf_vect_q & ovf_mask_i);

    // --------------------------------------------------
    // Quota
    // --------------------------------------------------
    // Sum of the counters selected by the mask
    always_comb begin
        quota_sum = '0;
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            if (quota_mask_i[i]) begin
                quota_sum = quota_sum + {2'b00, cnt_i[i]};
            end
        end
    end

    // An empty mask or a zero limit leaves the check idle
    assign quota_armed = (|quota_mask_i) && (|quota_limit_i);
    assign quota_hit   = quota_armed && (quota_sum >= {2'b00, quota_limit_i});

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            quota_q <= 1'b0;
        end else if (cfg_i.quota_softrst) begin
            quota_q <= 1'b0;
        end else if (quota_hit) begin
            quota_q <= 1'b1;
        end
    end

    assign intr_quota_o = quota_q;

endmodule

/* pmu_top.sv */
// PMU top level: register control block feeding the event, counter and interrupt path
`include "pmu_params.svh"

module pmu_top (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  pmu_pkg::reg_req_t         req_i,
    input  logic [`PMU_N_SOC_EV-1:0]  events_i,
    output logic [`PMU_REG_WIDTH-1:0] rdata_o,
    output logic                      rvalid_o,
    output logic                      intr_overflow_o,
    output logic                      intr_quota_o
);

    // Control to datapath
    pmu_pkg::pmu_cfg_t          cfg;
    pmu_pkg::cnt_wr_t           cnt_wr;
    logic [`PMU_XBAR_WIDTH-1:0] xbar_sel;
    logic [`PMU_N_COUNTERS-1:0] ovf_mask;
    logic [`PMU_N_COUNTERS-1:0] quota_mask;
    logic [`PMU_REG_WIDTH-1:0]  quota_limit;

    // Datapath back to control
    logic [`PMU_N_COUNTERS-1:0] inc;
    pmu_pkg::cnt_vec_t          cnt;
    logic [`PMU_N_COUNTERS-1:0] wrap;
    logic [`PMU_N_COUNTERS-1:0] ovf_vect;

    pmu_ctrl ctrl_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .req_i         (req_i),
        .cnt_i         (cnt),
        .ovf_vect_i    (ovf_vect),
        .cfg_o         (cfg),
        .xbar_sel_o    (xbar_sel),
        .cnt_wr_o      (cnt_wr),
        .ovf_mask_o    (ovf_mask),
        .quota_mask_o  (quota_mask),
        .quota_limit_o (quota_limit),
        .rdata_o       (rdata_o),
        .rvalid_o      (rvalid_o)
    );

    pmu_event_sel event_sel_i (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .events_i   (events_i),
        .xbar_sel_i (xbar_sel),
        .selftest_i (cfg.selftest),
        .inc_o      (inc)
    );

    pmu_counters counters_i (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .cfg_i    (cfg),
        .inc_i    (inc),
        .cnt_wr_i (cnt_wr),
        .cnt_o    (cnt),
        .wrap_o   (wrap)
    );

    pmu_irq irq_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .cfg_i           (cfg),
        .cnt_i           (cnt),
        .wrap_i          (wrap),
        .ovf_mask_i      (ovf_mask),
        .quota_mask_i    (quota_mask),
        .quota_limit_i   (quota_limit),
        .ovf_vect_o      (ovf_vect),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

endmodule

/* pmu_chk.sv */
// PMU protocol checker: read response timing, reset values and sticky interrupts
`include "pmu_params.svh"

module pmu_chk (
    input logic                      clk_i,
    input logic                      rstn_i,
    input pmu_pkg::reg_req_t         req_i,
    input pmu_pkg::pmu_cfg_t         cfg_i,
    input logic [`PMU_REG_WIDTH-1:0] rdata_i,
    input logic                      rvalid_i,
    input logic                      intr_overflow_i,
    input logic                      intr_quota_i
);

    // Failed assertions, summed up by the testbench
    int   assert_errs = 0;
    logic mask_wr;

    // A mask write may drop the overflow interrupt
    assign mask_wr = (req_i.op == pmu_pkg::REG_WRITE) && (req_i.addr == `PMU_ADDR_OVF_MASK);

    // --------------------------------------------------
    // Register port
    // --------------------------------------------------
    // Read data valid exactly one cycle after each read
    rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rvalid_i == $past(req_i.op == pmu_pkg::REG_READ))
    else begin
        assert_errs++;
        $error("rvalid does not follow the read request by one cycle");
    end

    // All outputs quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk_i)
        !rstn_i |=> (!rvalid_i && !intr_overflow_i && !intr_quota_i && rdata_i == '0))
    else begin
        assert_errs++;
        $error("outputs not zero during reset");
    end

    // --------------------------------------------------
    // Interrupts
    // --------------------------------------------------
    quota_sticky: assert property (@(posedge clk_i)
        rstn_i && intr_quota_i && !cfg_i.quota_softrst |=> intr_quota_i)
    else begin
        assert_errs++;
        $error("quota interrupt fell without a soft reset");
    end

    overflow_sticky: assert property (@(posedge clk_i)
        rstn_i && intr_overflow_i && !cfg_i.ovf_softrst && !mask_wr |=> intr_overflow_i)
    else begin
        assert_errs++;
        $error("overflow interrupt fell without a soft reset or mask write");
    end

endmodule

bind pmu_top pmu_chk chk_i (
    .clk_i           (clk_i),
    .rstn_i          (rstn_i),
    .req_i           (req_i),
    .cfg_i           (cfg),
    .rdata_i         (rdata_o),
    .rvalid_i        (rvalid_o),
    .intr_overflow_i (intr_overflow_o),
    .intr_quota_i    (intr_quota_o)
);

/* tb_pmu.sv */
// PMU directed testbench: register readback, event counting and interrupt checks
`include "pmu_params.svh"

module tb_pmu;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int XBAR_CYCLES  = 64;
    localparam int ST_CYCLES    = 20;
    localparam int QUOTA_CHUNKS = 6;
    localparam int QUOTA_LIMIT  = 30;

    // Rough test lengths in cycles, one register access takes about four
    localparam int T_RESET  = 32 * 4;
    localparam int T_XBAR   = XBAR_CYCLES + 16 * 4;
    localparam int T_SELF   = 3 * (ST_CYCLES + 12 * 4) + 60;
    localparam int T_OVF    = 16 * 4;
    localparam int T_QUOTA  = QUOTA_CHUNKS * 8 * 4 + 40;
    localparam int WD_CYCLES = RESET_CYCLES + T_RESET + T_XBAR + T_SELF + T_OVF + T_QUOTA + 200;

    // Configuration register bits
    localparam logic [31:0] CFG_CNT_EN     = 32'h01;
    localparam logic [31:0] CFG_CNT_SRST   = 32'h02;
    localparam logic [31:0] CFG_OVF_EN     = 32'h04;
    localparam logic [31:0] CFG_OVF_SRST   = 32'h08;
    localparam logic [31:0] CFG_QUOTA_SRST = 32'h10;

    logic                      clk_i;
    logic                      rstn_i;
    pmu_pkg::reg_req_t         req;
    logic [`PMU_N_SOC_EV-1:0]  events;
    logic [`PMU_REG_WIDTH-1:0] rdata;
    logic                      rvalid;
    logic                      intr_overflow;
    logic                      intr_quota;

    int data_errs  = 0;
    int irq_errs   = 0;
    int proto_errs = 0;

    pmu_top dut_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .req_i           (req),
        .events_i        (events),
        .rdata_o         (rdata),
        .rvalid_o        (rvalid),
        .intr_overflow_o (intr_overflow),
        .intr_quota_o    (intr_quota)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // Compare tasks and register access
    // --------------------------------------------------
    task automatic check_data(input logic [`PMU_REG_WIDTH-1:0] got,
                              input logic [`PMU_REG_WIDTH-1:0] exp, input string msg);
        if (got !== exp) begin
            data_errs++;
            $display("FAILED at %0t: %s, read %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // Pair is {overflow, quota}
    task automatic check_irq(input logic [1:0] got, input logic [1:0] exp, input string msg);
        if (got !== exp) begin
            irq_errs++;
            $display("FAILED at %0t: %s, interrupts %b, expected %b", $time, msg, got, exp);
        end
    endtask

    function automatic logic [`PMU_ADDR_WIDTH-1:0] cnt_addr(input int idx);
        return `PMU_ADDR_CNT_BASE + idx[`PMU_ADDR_WIDTH-1:0];
    endfunction

    // Self-test mode lives in bits 31:30
    function automatic logic [31:0] mode_bits(input pmu_pkg::selftest_e mode);
        return {mode, 30'd0};
    endfunction

    // Write lands on the second edge, the task returns right after it
    task automatic write_reg(input logic [`PMU_ADDR_WIDTH-1:0] addr,
                             input logic [`PMU_REG_WIDTH-1:0] data);
        pmu_pkg::reg_req_t r;
        r.op    = pmu_pkg::REG_WRITE;
        r.addr  = addr;
        r.wdata = data;
        @(posedge clk_i);
        req <= r;
        @(posedge clk_i);
        req <= '0;
    endtask

    task automatic read_reg(input logic [`PMU_ADDR_WIDTH-1:0] addr,
                            output logic [`PMU_REG_WIDTH-1:0] data);
        pmu_pkg::reg_req_t r;
        int waited;
        r.op    = pmu_pkg::REG_READ;
        r.addr  = addr;
        r.wdata = '0;
        waited  = 0;
        @(posedge clk_i);
        req <= r;
        @(posedge clk_i);
        req <= '0;
        // Valid expected in the first cycle after the request
        @(negedge clk_i);
        while (!rvalid && waited < 4) begin
            @(negedge clk_i);
            waited++;
        end
        if (!rvalid) begin
            proto_errs++;
            $display("Read of address %0d never returned valid data", addr);
        end else if (waited != 0) begin
            proto_errs++;
            $display("Read of address %0d returned %0d cycles late", addr, waited);
        end
        data = rdata;
    endtask

    task automatic read_and_check(input logic [`PMU_ADDR_WIDTH-1:0] addr,
                                  input logic [`PMU_REG_WIDTH-1:0] exp, input string msg);
        logic [`PMU_REG_WIDTH-1:0] d;
        read_reg(addr, d);
        check_data(d, exp, msg);
    endtask

    task automatic clear_counters();
        write_reg(`PMU_ADDR_CFG, CFG_CNT_SRST);
        write_reg(`PMU_ADDR_CFG, '0);
    endtask

    // Counts for exactly n edges with random events on the pins, n at least 2
    task automatic run_enabled(input logic [31:0] base, input int n);
        write_reg(`PMU_ADDR_CFG, base | CFG_CNT_EN);
        repeat (n - 2) begin
            @(posedge clk_i);
            events <= $urandom;
        end
        write_reg(`PMU_ADDR_CFG, base);
        events <= '0;
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic reset_readback();
        logic [31:0] v;
        for (int a = 0; a < 16; a++) begin
            read_and_check(a[`PMU_ADDR_WIDTH-1:0], '0, "value after reset");
        end
        @(negedge clk_i);
        check_irq({intr_overflow, intr_quota}, 2'b00, "interrupts after reset");
        // Unused config bits are stored too
        v = mode_bits(pmu_pkg::SELFTEST_ALL_OFF) | 32'h0000_0A44;
        write_reg(`PMU_ADDR_CFG, v);
        read_and_check(`PMU_ADDR_CFG, v, "config readback");
        v = $urandom;
        write_reg(`PMU_ADDR_OVF_MASK, v);
        read_and_check(`PMU_ADDR_OVF_MASK, v & 32'hF, "overflow mask readback");
        v = $urandom;
        write_reg(`PMU_ADDR_QUOTA_MASK, v);
        read_and_check(`PMU_ADDR_QUOTA_MASK, v & 32'hF, "quota mask readback");
        v = $urandom;
        write_reg(`PMU_ADDR_QUOTA_LIMIT, v);
        read_and_check(`PMU_ADDR_QUOTA_LIMIT, v, "quota limit readback");
        v = $urandom;
        write_reg(`PMU_ADDR_XBAR, v);
        read_and_check(`PMU_ADDR_XBAR, v & 32'hFFFF, "crossbar readback");
        write_reg(`PMU_ADDR_CFG, '0);
        write_reg(`PMU_ADDR_OVF_MASK, '0);
        write_reg(`PMU_ADDR_QUOTA_MASK, '0);
        write_reg(`PMU_ADDR_QUOTA_LIMIT, '0);
    endtask

    task automatic crossbar_count();
        int                         exp_cnt [`PMU_N_COUNTERS];
        logic [`PMU_XBAR_WIDTH-1:0] sel;
        logic [`PMU_N_SOC_EV-1:0]   ev;
        sel = $urandom;
        write_reg(`PMU_ADDR_XBAR, sel);
        clear_counters();
        write_reg(`PMU_ADDR_CFG, CFG_CNT_EN);
        for (int i = 0; i < `PMU_N_COUNTERS; i++) exp_cnt[i] = 0;
        repeat (XBAR_CYCLES) begin
            @(posedge clk_i);
            ev = $urandom;
            events <= ev;
            for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
                if (ev[sel[i*`PMU_SEL_BITS +: `PMU_SEL_BITS]]) exp_cnt[i]++;
            end
        end
        @(posedge clk_i);
        events <= '0;
        repeat (3) @(posedge clk_i);
        write_reg(`PMU_ADDR_CFG, '0);
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            read_and_check(cnt_addr(i), exp_cnt[i], "crossbar count");
        end
    endtask

    task automatic selftest_modes();
        pmu_pkg::selftest_e modes [3];
        int                 exp;
        modes[0] = pmu_pkg::SELFTEST_ALL_ON;
        modes[1] = pmu_pkg::SELFTEST_ALL_OFF;
        modes[2] = pmu_pkg::SELFTEST_ONE_ON;
        for (int m = 0; m < 3; m++) begin
            clear_counters();
            write_reg(`PMU_ADDR_CFG, mode_bits(modes[m]));
            run_enabled(mode_bits(modes[m]), ST_CYCLES);
            for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
                if (modes[m] == pmu_pkg::SELFTEST_ALL_ON) exp = ST_CYCLES;
                else if (modes[m] == pmu_pkg::SELFTEST_ONE_ON && i == 0) exp = ST_CYCLES;
                else exp = 0;
                read_and_check(cnt_addr(i), exp, "self-test count");
            end
        end
        // Constant events with counting off, values from ONE_ON must hold
        write_reg(`PMU_ADDR_CFG, mode_bits(pmu_pkg::SELFTEST_ALL_ON));
        repeat (10) @(posedge clk_i);
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            read_and_check(cnt_addr(i), (i == 0) ? ST_CYCLES : 0, "hold with counting off");
        end
        write_reg(`PMU_ADDR_CFG, '0);
    endtask

    task automatic overflow_irq();
        logic [31:0] base;
        base = mode_bits(pmu_pkg::SELFTEST_ALL_ON) | CFG_OVF_EN;
        clear_counters();
        write_reg(`PMU_ADDR_OVF_MASK, 32'h1);
        write_reg(`PMU_ADDR_CFG, base);
        write_reg(cnt_addr(1), 32'hFFFF_FFFD);
        // FD, FE, FF, wrap to 0, then 1
        run_enabled(base, 4);
        read_and_check(cnt_addr(1), 32'd1, "counter 1 after wrap");
        read_and_check(cnt_addr(0), 32'd4, "counter 0 next to the wrap");
        read_and_check(`PMU_ADDR_OVF_VECT, 32'h2, "overflow vector after wrap");
        @(negedge clk_i);
        check_irq({intr_overflow, intr_quota}, 2'b00, "overflow bit masked off");
        write_reg(`PMU_ADDR_OVF_MASK, 32'h2);
        @(negedge clk_i);
        check_irq({intr_overflow, intr_quota}, 2'b10, "overflow bit unmasked");
        write_reg(`PMU_ADDR_CFG, base | CFG_OVF_SRST);
        write_reg(`PMU_ADDR_CFG, base);
        @(negedge clk_i);
        check_irq({intr_overflow, intr_quota}, 2'b00, "after overflow soft reset");
        read_and_check(`PMU_ADDR_OVF_VECT, '0, "overflow vector after soft reset");
        write_reg(`PMU_ADDR_CFG, '0);
        write_reg(`PMU_ADDR_OVF_MASK, '0);
    endtask

    task automatic quota_irq();
        logic [31:0] base;
        logic [31:0] c0;
        logic [31:0] c2;
        int          exp_cnt;
        logic        reached;
        base    = mode_bits(pmu_pkg::SELFTEST_ALL_ON);
        reached = 1'b0;
        clear_counters();
        // Counters 0 and 2 make up the sum
        write_reg(`PMU_ADDR_QUOTA_MASK, 32'h5);
        write_reg(`PMU_ADDR_QUOTA_LIMIT, QUOTA_LIMIT);
        write_reg(`PMU_ADDR_CFG, base);
        for (int k = 0; k < QUOTA_CHUNKS; k++) begin
            run_enabled(base, 4);
            exp_cnt = (k + 1) * 4;
            read_reg(cnt_addr(0), c0);
            read_reg(cnt_addr(2), c2);
            check_data(c0, exp_cnt, "quota counter 0");
            check_data(c2, exp_cnt, "quota counter 2");
            // Both masked counters step together
            reached = reached || ((2 * exp_cnt) >= QUOTA_LIMIT);
            @(negedge clk_i);
            check_irq({intr_overflow, intr_quota}, {1'b0, reached}, "quota against masked sum");
        end
        // Sum falls back to zero, the flag stays up
        write_reg(`PMU_ADDR_CFG, CFG_CNT_SRST);
        write_reg(`PMU_ADDR_CFG, '0);
        @(negedge clk_i);
        check_irq({intr_overflow, intr_quota}, 2'b01, "quota held after counter clear");
        write_reg(`PMU_ADDR_CFG, CFG_QUOTA_SRST);
        write_reg(`PMU_ADDR_CFG, '0);
        @(negedge clk_i);
        check_irq({intr_overflow, intr_quota}, 2'b00, "after quota soft reset");
        write_reg(`PMU_ADDR_QUOTA_MASK, '0);
        write_reg(`PMU_ADDR_QUOTA_LIMIT, '0);
    endtask

    // --------------------------------------------------
    // Watchdog and main sequence
    // --------------------------------------------------
    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("Timeout: tests still running after %0d cycles", WD_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int total;
        void'($urandom(62));
        rstn_i = 1'b0;
        req    = '0;
        events = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rstn_i <= 1'b1;
        reset_readback();
        crossbar_count();
        selftest_modes();
        overflow_irq();
        quota_irq();
        repeat (4) @(posedge clk_i);
        total = data_errs + irq_errs + proto_errs + dut_i.chk_i.assert_errs;
        $display("Errors: data %0d, interrupt %0d, protocol %0d, assertion %0d",
                 data_errs, irq_errs, proto_errs, dut_i.chk_i.assert_errs);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+.
pmu_pkg.sv
pmu_ctrl.sv
pmu_event_sel.sv
pmu_counters.sv
pmu_irq.sv
pmu_top.sv
pmu_chk.sv
tb_pmu.sv

/* Bender.yml */
package:
  name: pmu

export_include_dirs:
  - .

sources:
  - pmu_pkg.sv
  - pmu_ctrl.sv
  - pmu_event_sel.sv
  - pmu_counters.sv
  - pmu_irq.sv
  - pmu_top.sv
  - target: test
    files:
      - pmu_chk.sv
      - tb_pmu.sv
